//--- hdl/image_pipe_macros.svh
// image pipe sizes
// word, lane and kernel dimensions shared by the front end blocks

`ifndef IMAGE_PIPE_MACROS_SVH
`define IMAGE_PIPE_MACROS_SVH

// ----------------------------------------------------------------------
// pixel words
// ----------------------------------------------------------------------
`define IP_WORD_WIDTH   8   // bits per pixel word

// ----------------------------------------------------------------------
// lanes and kernel
// ----------------------------------------------------------------------
`define IP_UNITS        4   // output words per lane
`define IP_KH_MAX       5   // largest odd kernel height
`define IP_KH2_MAX      2   // KH_MAX/2, rounded down

// input words per lane, padded with edges on both sides
`define IP_UNITS_EDGES  (`IP_UNITS + `IP_KH_MAX - 1)

// ----------------------------------------------------------------------
// counter widths
// ----------------------------------------------------------------------
`define IP_BITS_KH2     2   // holds kh2
`define IP_BITS_SHIFT   3   // holds 2*KH2_MAX

`endif

//--- hdl/image_pipe_pkg.sv
// image pipe types
// pixel word, half kernel height and sequencer state

`include "image_pipe_macros.svh"

package image_pipe_pkg;

  // ----------------------------------------------------------------------
  // data types
  // ----------------------------------------------------------------------

  // one pixel word on a lane
  typedef logic [`IP_WORD_WIDTH-1:0] word_t;

  // half kernel height, as carried in header word 1
  typedef logic [`IP_BITS_KH2-1:0] kh2_t;

  // ----------------------------------------------------------------------
  // sequencer state
  // ----------------------------------------------------------------------

  // set_s   waits for the header beat of a frame
  // ones_s  sends kh2+1 config beats
  // pass_s  forwards pixel beats until the last beat of input 1
  typedef enum logic [1:0] {
    set_s  = 2'd0,
    ones_s = 2'd1,
    pass_s = 2'd2
  } pipe_state_e;

endpackage

//--- hdl/image_config_sequencer.sv
// image config sequencer
// reads the frame header, emits config beats, then muxes inputs 1 and 2 onto two lanes

`timescale 1ns/1ps
`include "image_pipe_macros.svh"

module image_config_sequencer (
  input  logic                  aclk,
  input  logic                  rst_n,
  input  logic                  s_1_valid,
  input  logic                  s_1_last,
  input  image_pipe_pkg::word_t s_1_data [`IP_UNITS_EDGES],
  output logic                  s_1_ready,
  input  logic                  s_2_valid,
  input  image_pipe_pkg::word_t s_2_data [`IP_UNITS_EDGES],
  output logic                  s_2_ready,
  output logic                  seq_valid,
  input  logic                  seq_ready,
  output image_pipe_pkg::word_t seq_data_1 [`IP_UNITS_EDGES],
  output image_pipe_pkg::word_t seq_data_2 [`IP_UNITS_EDGES],
  output logic                  seq_is_max,
  output image_pipe_pkg::kh2_t  seq_kh2,
  output logic                  seq_is_config
);
  import image_pipe_pkg::*;

  localparam int UNITS_EDGES = `IP_UNITS_EDGES;
  localparam int KH2_MAX     = `IP_KH2_MAX;
  localparam int BITS_KH2    = `IP_BITS_KH2;

  pipe_state_e state;
  logic        is_max_q;   // header word 0
  kh2_t        kh2_q;      // header word 1
  kh2_t        ones_cnt;   // config beats sent so far
  logic        s_1_hs;
  logic        seq_hs;

  assign s_1_hs = s_1_valid && s_1_ready;
  assign seq_hs = seq_valid && seq_ready;

  // ----------------------------------------------------------------------
  // state and header registers
  // ----------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state    <= set_s;
      is_max_q <= 1'b0;
      kh2_q    <= '0;
      ones_cnt <= '0;
    end else begin
      case (state)
        set_s: begin
          if (s_1_hs) begin
            is_max_q <= s_1_data[0][0];
            kh2_q    <= s_1_data[1][BITS_KH2-1:0];
            ones_cnt <= '0;
            state    <= ones_s;
          end
        end
        ones_s: begin
          if (seq_hs) begin
            if (ones_cnt == kh2_q) state <= pass_s;  // kh2+1 beats done
            else ones_cnt <= ones_cnt + 1'b1;
          end
        end
        pass_s: begin
          if (s_1_hs && s_1_last) state <= set_s;
        end
        default: state <= set_s;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // handshake, joined across both inputs in max mode
  // ----------------------------------------------------------------------
  always_comb begin
    seq_valid = 1'b0;
    s_1_ready = 1'b0;
    s_2_ready = 1'b0;
    case (state)
      set_s:  s_1_ready = seq_ready;   // header is swallowed, not forwarded
      ones_s: seq_valid = 1'b1;
      pass_s: begin
        if (is_max_q) begin
          seq_valid = s_1_valid && s_2_valid;
          s_1_ready = seq_ready && s_2_valid;
          s_2_ready = seq_ready && s_1_valid;
        end else begin
          seq_valid = s_1_valid;
          s_1_ready = seq_ready;
        end
      end
      default: ;
    endcase
  end

  // ----------------------------------------------------------------------
  // lane mux
  // ----------------------------------------------------------------------

  // config beats carry ones on the first KH2_MAX+1 words and zeros elsewhere
  always_comb begin
    for (int u = 0; u < UNITS_EDGES; u++) begin
      if (state == ones_s) begin
        seq_data_1[u] = (u <= KH2_MAX) ? word_t'(1) : word_t'(0);
        seq_data_2[u] = (u <= KH2_MAX) ? word_t'(1) : word_t'(0);
      end else begin
        seq_data_1[u] = s_1_data[u];
        seq_data_2[u] = is_max_q ? s_2_data[u] : s_1_data[u];
      end
    end
  end

  assign seq_is_max    = is_max_q;
  assign seq_kh2       = kh2_q;
  assign seq_is_config = (state == ones_s);

  // input 2 is consumed only in a max frame, together with input 1 and the lane beat
  a_s2_joined: assert property (@(posedge aclk) disable iff (!rst_n)
    (s_2_valid && s_2_ready) |-> (state == pass_s && is_max_q && s_1_hs && seq_hs));

endmodule

//--- hdl/image_shift_buffer.sv
// image shift buffer
// de-centers each beat by kh2 and shifts it out 2*kh2+1 times, holding the input off meanwhile

`timescale 1ns/1ps
`include "image_pipe_macros.svh"

module image_shift_buffer (
  input  logic                  aclk,
  input  logic                  rst_n,
  input  logic                  seq_valid,
  output logic                  seq_ready,
  input  image_pipe_pkg::word_t seq_data_1 [`IP_UNITS_EDGES],
  input  image_pipe_pkg::word_t seq_data_2 [`IP_UNITS_EDGES],
  input  logic                  seq_is_max,
  input  image_pipe_pkg::kh2_t  seq_kh2,
  input  logic                  seq_is_config,
  output logic                  buf_valid,
  input  logic                  buf_ready,
  output image_pipe_pkg::word_t buf_data_1 [`IP_UNITS],
  output image_pipe_pkg::word_t buf_data_2 [`IP_UNITS],
  output logic                  buf_is_max,
  output image_pipe_pkg::kh2_t  buf_kh2,
  output logic                  buf_is_config
);
  import image_pipe_pkg::*;

  localparam int UNITS       = `IP_UNITS;
  localparam int UNITS_EDGES = `IP_UNITS_EDGES;
  localparam int KH2_MAX     = `IP_KH2_MAX;
  localparam int BITS_SHIFT  = `IP_BITS_SHIFT;

  word_t                 dec_1 [UNITS_EDGES];   // de-centered input, lane 1
  word_t                 dec_2 [UNITS_EDGES];
  word_t                 buf_1_q [UNITS_EDGES];
  word_t                 buf_2_q [UNITS_EDGES];
  logic [BITS_SHIFT-1:0] count_q;               // shifts still to emit
  logic [BITS_SHIFT-1:0] shift_load;

  // new beats only enter once the previous one is fully shifted out
  assign seq_ready  = (count_q == '0) && buf_ready;
  assign shift_load = seq_is_config ? '0 : (BITS_SHIFT'(seq_kh2) << 1);

  // ----------------------------------------------------------------------
  // de-centering
  // ----------------------------------------------------------------------

  // the input is padded for KH_MAX, so a smaller kernel starts further in
  always_comb begin
    int src;
    for (int u = 0; u < UNITS_EDGES; u++) begin
      src = u + KH2_MAX - int'(seq_kh2);
      if (src >= 0 && src < UNITS_EDGES) begin
        dec_1[u] = seq_data_1[src];
        dec_2[u] = seq_data_2[src];
      end else begin
        dec_1[u] = '0;
        dec_2[u] = '0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      buf_valid <= 1'b0;
      count_q   <= '0;
    end else if (buf_ready) begin
      if (count_q == '0) begin
        buf_valid <= seq_valid;
        count_q   <= seq_valid ? shift_load : '0;
      end else begin
        count_q <= count_q - 1'b1;  // valid stays high while shifting
      end
    end
  end

  // ----------------------------------------------------------------------
  // payload, loaded on a fresh beat and shifted down one word otherwise
  // ----------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (buf_ready) begin
      if (count_q == '0) begin
        buf_1_q       <= dec_1;
        buf_2_q       <= dec_2;
        buf_is_max    <= seq_is_max;
        buf_kh2       <= seq_kh2;
        buf_is_config <= seq_is_config;
      end else begin
        for (int u = 0; u < UNITS_EDGES-1; u++) begin
          buf_1_q[u] <= buf_1_q[u+1];
          buf_2_q[u] <= buf_2_q[u+1];
        end
        buf_1_q[UNITS_EDGES-1] <= '0;   // zero fill from the top
        buf_2_q[UNITS_EDGES-1] <= '0;
      end
    end
  end

  always_comb begin
    for (int u = 0; u < UNITS; u++) begin
      buf_data_1[u] = buf_1_q[u];
      buf_data_2[u] = buf_2_q[u];
    end
  end

  // a pixel beat with kh2 > 0 keeps the input held off on the next cycle
  a_hold_input: assert property (@(posedge aclk) disable iff (!rst_n)
    (seq_valid && seq_ready && !seq_is_config && seq_kh2 != '0) |=> !seq_ready);

endmodule

//--- hdl/image_output_slice.sv
// image output slice
// main plus skid register, so the output side can stall without losing beats

`timescale 1ns/1ps
`include "image_pipe_macros.svh"

module image_output_slice (
  input  logic                  aclk,
  input  logic                  rst_n,
  input  logic                  buf_valid,
  output logic                  buf_ready,
  input  image_pipe_pkg::word_t buf_data_1 [`IP_UNITS],
  input  image_pipe_pkg::word_t buf_data_2 [`IP_UNITS],
  input  logic                  buf_is_max,
  input  image_pipe_pkg::kh2_t  buf_kh2,
  input  logic                  buf_is_config,
  output logic                  m_valid,
  input  logic                  m_ready,
  output image_pipe_pkg::word_t m_data_1 [`IP_UNITS],
  output image_pipe_pkg::word_t m_data_2 [`IP_UNITS],
  output logic                  m_is_max,
  output image_pipe_pkg::kh2_t  m_kh2,
  output logic                  m_is_config
);
  import image_pipe_pkg::*;

  localparam int UNITS      = `IP_UNITS;
  localparam int WORD_WIDTH = `IP_WORD_WIDTH;

  word_t                       skid_data_1 [UNITS];
  word_t                       skid_data_2 [UNITS];
  logic                        skid_is_max;
  kh2_t                        skid_kh2;
  logic                        skid_is_config;
  logic                        skid_valid;
  logic                        skid_valid_next;
  logic                        in_hs;
  logic                        out_free;   // main register can take a beat
  logic [UNITS*WORD_WIDTH-1:0] m_flat_1;
  logic [UNITS*WORD_WIDTH-1:0] m_flat_2;

  assign in_hs    = buf_valid && buf_ready;
  assign out_free = !m_valid || m_ready;

  // skid fills only when a beat arrives while the output is stalled
  always_comb begin
    skid_valid_next = skid_valid;
    if (out_free) skid_valid_next = 1'b0;
    else if (in_hs) skid_valid_next = 1'b1;
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
      buf_ready  <= 1'b0;
    end else begin
      skid_valid <= skid_valid_next;
      buf_ready  <= !skid_valid_next;
      if (out_free) m_valid <= skid_valid || in_hs;
    end
  end

  always_ff @(posedge aclk) begin
    if (out_free) begin
      m_data_1    <= skid_valid ? skid_data_1 : buf_data_1;
      m_data_2    <= skid_valid ? skid_data_2 : buf_data_2;
      m_is_max    <= skid_valid ? skid_is_max : buf_is_max;
      m_kh2       <= skid_valid ? skid_kh2 : buf_kh2;
      m_is_config <= skid_valid ? skid_is_config : buf_is_config;
    end
    if (buf_ready) begin   // skid is empty, keep it tracking the input
      skid_data_1    <= buf_data_1;
      skid_data_2    <= buf_data_2;
      skid_is_max    <= buf_is_max;
      skid_kh2       <= buf_kh2;
      skid_is_config <= buf_is_config;
    end
  end

  assign m_flat_1 = {>>{m_data_1}};
  assign m_flat_2 = {>>{m_data_2}};

  a_out_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_flat_1) && $stable(m_flat_2)
                               && $stable({m_is_max, m_kh2, m_is_config})));

endmodule

//--- hdl/image_pipe_top.sv
// image pipe top
// config sequencer, shift buffer and output slice in a chain

`timescale 1ns/1ps
`include "image_pipe_macros.svh"

module image_pipe_top (
  input  logic                  aclk,
  input  logic                  rst_n,
  input  logic                  s_1_valid,
  input  logic                  s_1_last,
  input  image_pipe_pkg::word_t s_1_data [`IP_UNITS_EDGES],
  output logic                  s_1_ready,
  input  logic                  s_2_valid,
  input  image_pipe_pkg::word_t s_2_data [`IP_UNITS_EDGES],
  output logic                  s_2_ready,
  output logic                  m_valid,
  input  logic                  m_ready,
  output image_pipe_pkg::word_t m_data_1 [`IP_UNITS],
  output image_pipe_pkg::word_t m_data_2 [`IP_UNITS],
  output logic                  m_is_max,
  output image_pipe_pkg::kh2_t  m_kh2,
  output logic                  m_is_config
);
  import image_pipe_pkg::*;

  localparam int UNITS       = `IP_UNITS;
  localparam int UNITS_EDGES = `IP_UNITS_EDGES;

  // ----------------------------------------------------------------------
  // sequencer to buffer
  // ----------------------------------------------------------------------
  logic  seq_valid;
  logic  seq_ready;
  word_t seq_data_1 [UNITS_EDGES];
  word_t seq_data_2 [UNITS_EDGES];
  logic  seq_is_max;
  kh2_t  seq_kh2;
  logic  seq_is_config;

  // ----------------------------------------------------------------------
  // buffer to slice
  // ----------------------------------------------------------------------
  logic  buf_valid;
  logic  buf_ready;
  word_t buf_data_1 [UNITS];
  word_t buf_data_2 [UNITS];
  logic  buf_is_max;
  kh2_t  buf_kh2;
  logic  buf_is_config;

  // port and wire names match across the chain
  image_config_sequencer image_config_sequencer_inst (.*);

  image_shift_buffer image_shift_buffer_inst (.*);

  image_output_slice image_output_slice_inst (.*);

endmodule

//--- sim/image_pipe_tb.sv
// image pipe testbench
// directed frames through the front end, checked against a model of the beat rules

`timescale 1ns/1ps
`include "image_pipe_macros.svh"

module image_pipe_tb;
  import image_pipe_pkg::*;

  localparam int UNITS       = `IP_UNITS;
  localparam int UNITS_EDGES = `IP_UNITS_EDGES;
  localparam int KH2_MAX     = `IP_KH2_MAX;
  localparam int BITS_KH2    = `IP_BITS_KH2;
  localparam int WW          = `IP_WORD_WIDTH;
  localparam int LANE_W      = UNITS * WW;
  localparam int BEAT_W      = 2 + BITS_KH2 + 2 * LANE_W;   // {cfg, max, kh2, lane 1, lane 2}
  localparam int HS_LIMIT    = 200;
  localparam int OUT_LIMIT   = 4000;

  logic  aclk;
  logic  rst_n;
  logic  s_1_valid;
  logic  s_1_last;
  word_t s_1_data [UNITS_EDGES];
  logic  s_1_ready;
  logic  s_2_valid;
  word_t s_2_data [UNITS_EDGES];
  logic  s_2_ready;
  logic  m_valid;
  logic  m_ready;
  word_t m_data_1 [UNITS];
  word_t m_data_2 [UNITS];
  logic  m_is_max;
  kh2_t  m_kh2;
  logic  m_is_config;

  logic [BEAT_W-1:0] exp_q [$];
  logic [BEAT_W-1:0] got_q [$];
  int                errors;
  int                checks;
  integer            seed;
  logic [31:0]       rnd_word;
  logic              random_ready;   // test 4 only
  logic              s2_seen;        // sticky, input 2 was asked for

  image_pipe_top image_pipe_top_inst (.*);

  always #5 aclk = ~aclk;

  // ----------------------------------------------------------------------
  // output side: ready driver and beat monitor
  // ----------------------------------------------------------------------
  always @(posedge aclk) begin
    if (random_ready) begin
      rnd_word = $random(seed);
      m_ready <= rnd_word[0];
    end else begin
      m_ready <= 1'b1;
    end
  end

  always @(posedge aclk) begin
    if (rst_n && m_valid && m_ready) got_q.push_back(pack_output());
    if (rst_n && s_2_ready) s2_seen = 1'b1;
  end

  function automatic logic [BEAT_W-1:0] pack_output();
    logic [LANE_W-1:0] l1;
    logic [LANE_W-1:0] l2;
    for (int u = 0; u < UNITS; u++) begin
      l1[u*WW +: WW] = m_data_1[u];
      l2[u*WW +: WW] = m_data_2[u];
    end
    return {m_is_config, m_is_max, m_kh2, l1, l2};
  endfunction

  // distinct value per lane, beat and word
  function automatic word_t pixel_word(int lane, int beat, int idx, int base);
    return word_t'(base + 64 * lane + 8 * beat + idx);
  endfunction

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  task automatic model_frame(bit mx, int k, int n_pix, int base);
    logic [LANE_W-1:0] l1;
    logic [LANE_W-1:0] l2;
    int                src;
    // config beats: ones on words 0..KH2_MAX, then de-centered, no shift
    for (int c = 0; c <= k; c++) begin
      for (int u = 0; u < UNITS; u++) begin
        src = u + KH2_MAX - k;
        l1[u*WW +: WW] = (src <= KH2_MAX) ? word_t'(1) : word_t'(0);
        l2[u*WW +: WW] = (src <= KH2_MAX) ? word_t'(1) : word_t'(0);
      end
      exp_q.push_back({1'b1, mx, kh2_t'(k), l1, l2});
    end
    for (int b = 0; b < n_pix; b++) begin
      for (int j = 0; j <= 2 * k; j++) begin
        for (int u = 0; u < UNITS; u++) begin
          src = u + j + KH2_MAX - k;
          if (src < UNITS_EDGES) begin
            l1[u*WW +: WW] = pixel_word(1, b, src, base);
            l2[u*WW +: WW] = mx ? pixel_word(2, b, src, base) : pixel_word(1, b, src, base);
          end else begin
            l1[u*WW +: WW] = '0;
            l2[u*WW +: WW] = '0;
          end
        end
        exp_q.push_back({1'b0, mx, kh2_t'(k), l1, l2});
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // producers
  // ----------------------------------------------------------------------
  task automatic stop_on_timeout(string what);
    $display("timeout at %0t: no progress while waiting for %s", $time, what);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic wait_ready_1();
    int cnt;
    cnt = 0;
    do begin
      @(posedge aclk);
      cnt++;
    end while (!s_1_ready && cnt < HS_LIMIT);
    if (!s_1_ready) stop_on_timeout("s_1_ready");
  endtask

  task automatic wait_ready_2();
    int cnt;
    cnt = 0;
    do begin
      @(posedge aclk);
      cnt++;
    end while (!s_2_ready && cnt < HS_LIMIT);
    if (!s_2_ready) stop_on_timeout("s_2_ready");
  endtask

  task automatic drive_input_1(bit mx, int k, int n_pix, int base);
    for (int u = 0; u < UNITS_EDGES; u++)
      s_1_data[u] <= (u == 0) ? word_t'(mx) : (u == 1) ? word_t'(k) : word_t'(0);
    s_1_last  <= 1'b0;
    s_1_valid <= 1'b1;
    wait_ready_1();   // header
    for (int b = 0; b < n_pix; b++) begin
      for (int u = 0; u < UNITS_EDGES; u++) s_1_data[u] <= pixel_word(1, b, u, base);
      s_1_last <= (b == n_pix - 1);
      wait_ready_1();
    end
    s_1_valid <= 1'b0;
    s_1_last  <= 1'b0;
  endtask

  task automatic drive_input_2(int n_pix, int base);
    for (int b = 0; b < n_pix; b++) begin
      for (int u = 0; u < UNITS_EDGES; u++) s_2_data[u] <= pixel_word(2, b, u, base);
      s_2_valid <= 1'b1;
      wait_ready_2();
    end
    s_2_valid <= 1'b0;
  endtask

  task automatic run_frame(bit mx, int k, int n_pix, int base);
    model_frame(mx, k, n_pix, base);
    fork
      drive_input_1(mx, k, n_pix, base);
      if (mx) drive_input_2(n_pix, base);
    join
  endtask

  // ----------------------------------------------------------------------
  // checking
  // ----------------------------------------------------------------------
  task automatic check_output(string name);
    int cnt;
    int n;
    cnt = 0;
    while (got_q.size() < exp_q.size() && cnt < OUT_LIMIT) begin
      @(posedge aclk);
      cnt++;
    end
    if (got_q.size() < exp_q.size()) stop_on_timeout({name, " output beats"});
    cnt = 0;
    while (cnt < 20) begin   // idle cycles to catch extra beats
      @(posedge aclk);
      cnt++;
    end
    checks++;
    if (got_q.size() != exp_q.size()) begin
      errors++;
      $display("ERROR at %0t: %s got %0d beats, expected %0d", $time, name,
               got_q.size(), exp_q.size());
    end
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      checks++;
      if (got_q[i] !== exp_q[i]) begin
        errors++;
        $display("ERROR at %0t: %s beat %0d got %h expected %h", $time, name, i,
                 got_q[i], exp_q[i]);
      end
    end
  endtask

  function automatic int count_config(int k);
    int n;
    n = 0;
    foreach (got_q[i])
      if (got_q[i][BEAT_W-1] && got_q[i][2*LANE_W +: BITS_KH2] == k) n++;
    return n;
  endfunction

  task automatic check_count(string name, int got, int want);
    checks++;
    if (got != want) begin
      errors++;
      $display("ERROR at %0t: %s count %0d, expected %0d", $time, name, got, want);
    end
  endtask

  task automatic clear_queues();
    exp_q.delete();
    got_q.delete();
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic test_config_beats();
    clear_queues();
    run_frame(1'b0, 1, 2, 16);
    check_output("config beats");
    check_count("config beats with kh2=1", count_config(1), 2);
  endtask

  task automatic test_non_max_pass();
    clear_queues();
    s2_seen = 1'b0;
    run_frame(1'b0, 0, 4, 32);
    check_output("non-max pass");
    checks++;
    if (s2_seen) begin
      errors++;
      $display("ERROR at %0t: s_2_ready rose during a non-max frame", $time);
    end
  endtask

  task automatic test_max_shift();
    clear_queues();
    run_frame(1'b1, 2, 3, 48);
    check_output("max shift");
  endtask

  task automatic test_back_pressure();
    clear_queues();
    random_ready <= 1'b1;
    run_frame(1'b1, 1, 5, 80);
    check_output("back-pressure");
    random_ready <= 1'b0;
  endtask

  task automatic test_frame_boundary();
    clear_queues();
    run_frame(1'b1, 2, 2, 100);
    run_frame(1'b0, 0, 3, 140);   // new header right after s_1_last
    check_output("frame boundary");
    check_count("config beats with kh2=2", count_config(2), 3);
    check_count("config beats with kh2=0", count_config(0), 1);
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    aclk         = 1'b0;
    rst_n        = 1'b0;
    s_1_valid    = 1'b0;
    s_1_last     = 1'b0;
    s_2_valid    = 1'b0;
    m_ready      = 1'b1;
    random_ready = 1'b0;
    s2_seen      = 1'b0;
    errors       = 0;
    checks       = 0;
    seed         = 97;
    for (int u = 0; u < UNITS_EDGES; u++) begin
      s_1_data[u] = '0;
      s_2_data[u] = '0;
    end
    repeat (10) @(posedge aclk);
    checks++;
    if (m_valid || s_1_ready || s_2_ready) begin
      errors++;
      $display("ERROR at %0t: handshake outputs not low in reset", $time);
    end
    rst_n <= 1'b1;
    @(posedge aclk);

    test_config_beats();
    test_non_max_pass();
    test_max_shift();
    test_back_pressure();
    test_frame_boundary();

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+hdl
hdl/image_pipe_pkg.sv
hdl/image_config_sequencer.sv
hdl/image_shift_buffer.sv
hdl/image_output_slice.sv
hdl/image_pipe_top.sv
sim/image_pipe_tb.sv

//--- Bender.yml
package:
  name: image_pipe

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/image_pipe_pkg.sv
      - hdl/image_config_sequencer.sv
      - hdl/image_shift_buffer.sv
      - hdl/image_output_slice.sv
      - hdl/image_pipe_top.sv

  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/image_pipe_tb.sv
